/* design/decode_pkg.sv */
package decode_pkg;

  localparam int xlen       = 32;
  localparam int reg_addr_w = 5;
  localparam int alu_op_w   = 12;

  // bit positions inside alu_op_t
  localparam int alu_add  = 0;
  localparam int alu_sub  = 1;
  localparam int alu_slt  = 2;
  localparam int alu_sltu = 3;
  localparam int alu_and  = 4;
  localparam int alu_nor  = 5;
  localparam int alu_or   = 6;
  localparam int alu_xor  = 7;
  localparam int alu_sll  = 8;
  localparam int alu_srl  = 9;
  localparam int alu_sra  = 10;
  localparam int alu_lui  = 11;

  // major opcode, inst[31:26]
  localparam logic [5:0] op_grp_int   = 6'h00;
  localparam logic [5:0] op_lu12i_w   = 6'h05;
  localparam logic [5:0] op_pcaddu12i = 6'h07;
  localparam logic [5:0] op_grp_mem   = 6'h0a;
  localparam logic [5:0] op_jirl      = 6'h13;
  localparam logic [5:0] op_b         = 6'h14;
  localparam logic [5:0] op_bl        = 6'h15;
  localparam logic [5:0] op_beq       = 6'h16;
  localparam logic [5:0] op_bne       = 6'h17;
  localparam logic [5:0] op_blt       = 6'h18;
  localparam logic [5:0] op_bge       = 6'h19;
  localparam logic [5:0] op_bltu      = 6'h1a;
  localparam logic [5:0] op_bgeu      = 6'h1b;

  // inst[25:22] within the integer group
  localparam logic [3:0] op_sub_reg   = 4'h0;
  localparam logic [3:0] op_sub_shift = 4'h1;
  localparam logic [3:0] op_slti      = 4'h8;
  localparam logic [3:0] op_sltui     = 4'h9;
  localparam logic [3:0] op_addi_w    = 4'ha;
  localparam logic [3:0] op_andi      = 4'hd;
  localparam logic [3:0] op_ori       = 4'he;
  localparam logic [3:0] op_xori      = 4'hf;

  // inst[21:20]
  localparam logic [1:0] op_fmt_3r    = 2'h1;
  localparam logic [1:0] op_fmt_shift = 2'h0;

  // inst[19:15], three-register forms
  localparam logic [4:0] op_add_w = 5'h00;
  localparam logic [4:0] op_sub_w = 5'h02;
  localparam logic [4:0] op_slt   = 5'h04;
  localparam logic [4:0] op_sltu  = 5'h05;
  localparam logic [4:0] op_nor   = 5'h08;
  localparam logic [4:0] op_and   = 5'h09;
  localparam logic [4:0] op_or    = 5'h0a;
  localparam logic [4:0] op_xor   = 5'h0b;
  localparam logic [4:0] op_sll_w = 5'h0e;
  localparam logic [4:0] op_srl_w = 5'h0f;
  localparam logic [4:0] op_sra_w = 5'h10;

  // inst[19:15], shift by ui5
  localparam logic [4:0] op_slli_w = 5'h01;
  localparam logic [4:0] op_srli_w = 5'h09;
  localparam logic [4:0] op_srai_w = 5'h11;

  // inst[25:22] within the memory group
  localparam logic [3:0] op_ld_b  = 4'h0;
  localparam logic [3:0] op_ld_h  = 4'h1;
  localparam logic [3:0] op_ld_w  = 4'h2;
  localparam logic [3:0] op_st_b  = 4'h4;
  localparam logic [3:0] op_st_h  = 4'h5;
  localparam logic [3:0] op_st_w  = 4'h6;
  localparam logic [3:0] op_ld_bu = 4'h8;
  localparam logic [3:0] op_ld_hu = 4'h9;

  typedef logic [reg_addr_w-1:0] reg_addr_t;
  typedef logic [alu_op_w-1:0]   alu_op_t;

  typedef struct packed {
    logic [xlen-1:0] pc;
    logic [31:0]     inst;
  } fetch_slot_t;

  typedef struct packed {
    reg_addr_t raddr1;
    reg_addr_t raddr2;
  } rf_req_t;

  typedef struct packed {
    logic [xlen-1:0] rj_value;
    logic [xlen-1:0] rkd_value;
  } rf_data_t;

  // what the pairing rule looks at
  typedef struct packed {
    logic      gr_we;
    reg_addr_t dest;
    logic      use_rj;
    logic      use_rkd;
    logic      may_jump;
    logic      is_ls;
  } hazard_t;

  typedef struct packed {
    alu_op_t         alu_op;
    logic [3:0]      mem_width;
    logic            may_jump;
    logic            use_rj_value;
    logic            use_less;
    logic            need_less;
    logic            use_zero;
    logic            need_zero;
    logic            src1_is_pc;
    logic            src2_is_imm;
    logic            src2_is_4;
    logic            gr_we;
    logic            mem_we;
    logic            res_from_mem;
    logic            is_unsigned;
    reg_addr_t       dest;
    logic [xlen-1:0] imm;
    logic [xlen-1:0] rj_value;
    logic [xlen-1:0] rkd_value;
    logic [xlen-1:0] pc;
  } exe_slot_t;

endpackage

/* design/inst_decoder.sv */
`timescale 1ns/1ps

module inst_decoder (
  input  decode_pkg::fetch_slot_t fetch,
  input  decode_pkg::rf_data_t    rf_data,
  output decode_pkg::rf_req_t     rf_req,
  output decode_pkg::exe_slot_t   slot,
  output decode_pkg::hazard_t     hazard
);
  import decode_pkg::*;

  logic [31:0] inst;
  logic [5:0]  op_31_26;
  logic [3:0]  op_25_22;
  logic [1:0]  op_21_20;
  logic [4:0]  op_19_15;
  reg_addr_t   rd;
  reg_addr_t   rj;
  reg_addr_t   rk;

  logic grp_int;
  logic grp_mem;
  logic is_3r;
  logic is_shift_imm;

  logic inst_add_w, inst_sub_w, inst_slt, inst_sltu;
  logic inst_nor, inst_and, inst_or, inst_xor;
  logic inst_sll_w, inst_srl_w, inst_sra_w;
  logic inst_slli_w, inst_srli_w, inst_srai_w;
  logic inst_addi_w, inst_slti, inst_sltui;
  logic inst_andi, inst_ori, inst_xori;
  logic inst_lu12i_w, inst_pcaddu12i;
  logic inst_ld_b, inst_ld_h, inst_ld_w, inst_ld_bu, inst_ld_hu;
  logic inst_st_b, inst_st_h, inst_st_w;
  logic inst_jirl, inst_b, inst_bl;
  logic inst_beq, inst_bne, inst_blt, inst_bge, inst_bltu, inst_bgeu;

  logic ld_any;
  logic st_any;
  logic br_cond;
  logic alu_reg;
  logic alu_imm;

  alu_op_t         alu_op;
  logic [3:0]      mem_width;
  logic            need_ui5, need_si12, need_ui12, need_si16, need_si20, need_si26;
  logic [xlen-1:0] imm;
  logic            gr_we;
  logic            use_rj;
  logic            use_rkd;
  logic            may_jump;
  logic            src2_is_imm;
  logic            src_reg_is_rd;
  reg_addr_t       dest;

  assign inst     = fetch.inst;
  assign op_31_26 = inst[31:26];
  assign op_25_22 = inst[25:22];
  assign op_21_20 = inst[21:20];
  assign op_19_15 = inst[19:15];
  assign rd       = inst[4:0];
  assign rj       = inst[9:5];
  assign rk       = inst[14:10];

  assign grp_int      = op_31_26 == op_grp_int;
  assign grp_mem      = op_31_26 == op_grp_mem;
  assign is_3r        = grp_int && op_25_22 == op_sub_reg && op_21_20 == op_fmt_3r;
  assign is_shift_imm = grp_int && op_25_22 == op_sub_shift && op_21_20 == op_fmt_shift;

  assign inst_add_w  = is_3r && op_19_15 == op_add_w;
  assign inst_sub_w  = is_3r && op_19_15 == op_sub_w;
  assign inst_slt    = is_3r && op_19_15 == op_slt;
  assign inst_sltu   = is_3r && op_19_15 == op_sltu;
  assign inst_nor    = is_3r && op_19_15 == op_nor;
  assign inst_and    = is_3r && op_19_15 == op_and;
  assign inst_or     = is_3r && op_19_15 == op_or;
  assign inst_xor    = is_3r && op_19_15 == op_xor;
  assign inst_sll_w  = is_3r && op_19_15 == op_sll_w;
  assign inst_srl_w  = is_3r && op_19_15 == op_srl_w;
  assign inst_sra_w  = is_3r && op_19_15 == op_sra_w;
  assign inst_slli_w = is_shift_imm && op_19_15 == op_slli_w;
  assign inst_srli_w = is_shift_imm && op_19_15 == op_srli_w;
  assign inst_srai_w = is_shift_imm && op_19_15 == op_srai_w;

  assign inst_slti   = grp_int && op_25_22 == op_slti;
  assign inst_sltui  = grp_int && op_25_22 == op_sltui;
  assign inst_addi_w = grp_int && op_25_22 == op_addi_w;
  assign inst_andi   = grp_int && op_25_22 == op_andi;
  assign inst_ori    = grp_int && op_25_22 == op_ori;
  assign inst_xori   = grp_int && op_25_22 == op_xori;

  // bit 25 must be clear for both u12i forms
  assign inst_lu12i_w   = op_31_26 == op_lu12i_w && !inst[25];
  assign inst_pcaddu12i = op_31_26 == op_pcaddu12i && !inst[25];

  assign inst_ld_b  = grp_mem && op_25_22 == op_ld_b;
  assign inst_ld_h  = grp_mem && op_25_22 == op_ld_h;
  assign inst_ld_w  = grp_mem && op_25_22 == op_ld_w;
  assign inst_ld_bu = grp_mem && op_25_22 == op_ld_bu;
  assign inst_ld_hu = grp_mem && op_25_22 == op_ld_hu;
  assign inst_st_b  = grp_mem && op_25_22 == op_st_b;
  assign inst_st_h  = grp_mem && op_25_22 == op_st_h;
  assign inst_st_w  = grp_mem && op_25_22 == op_st_w;

  assign inst_jirl = op_31_26 == op_jirl;
  assign inst_b    = op_31_26 == op_b;
  assign inst_bl   = op_31_26 == op_bl;
  assign inst_beq  = op_31_26 == op_beq;
  assign inst_bne  = op_31_26 == op_bne;
  assign inst_blt  = op_31_26 == op_blt;
  assign inst_bge  = op_31_26 == op_bge;
  assign inst_bltu = op_31_26 == op_bltu;
  assign inst_bgeu = op_31_26 == op_bgeu;

  assign ld_any  = inst_ld_b | inst_ld_h | inst_ld_w | inst_ld_bu | inst_ld_hu;
  assign st_any  = inst_st_b | inst_st_h | inst_st_w;
  assign br_cond = inst_beq | inst_bne | inst_blt | inst_bge | inst_bltu | inst_bgeu;
  assign alu_reg = inst_add_w | inst_sub_w | inst_slt | inst_sltu | inst_nor | inst_and
                 | inst_or | inst_xor | inst_sll_w | inst_srl_w | inst_sra_w;
  assign alu_imm = inst_slli_w | inst_srli_w | inst_srai_w | inst_addi_w | inst_slti
                 | inst_sltui | inst_andi | inst_ori | inst_xori;

  // address math and link values go through the adder
  assign alu_op[alu_add]  = inst_add_w | inst_addi_w | ld_any | st_any | inst_jirl | inst_bl
                          | inst_pcaddu12i;
  assign alu_op[alu_sub]  = inst_sub_w | inst_beq | inst_bne;
  assign alu_op[alu_slt]  = inst_slt | inst_slti | inst_blt | inst_bge;
  assign alu_op[alu_sltu] = inst_sltu | inst_sltui | inst_bltu | inst_bgeu;
  assign alu_op[alu_and]  = inst_and | inst_andi;
  assign alu_op[alu_nor]  = inst_nor;
  assign alu_op[alu_or]   = inst_or | inst_ori;
  assign alu_op[alu_xor]  = inst_xor | inst_xori;
  assign alu_op[alu_sll]  = inst_sll_w | inst_slli_w;
  assign alu_op[alu_srl]  = inst_srl_w | inst_srli_w;
  assign alu_op[alu_sra]  = inst_sra_w | inst_srai_w;
  assign alu_op[alu_lui]  = inst_lu12i_w;

  assign need_ui5  = inst_slli_w | inst_srli_w | inst_srai_w;
  assign need_si12 = inst_addi_w | inst_slti | inst_sltui | ld_any | st_any;
  assign need_ui12 = inst_andi | inst_ori | inst_xori;
  assign need_si16 = inst_jirl | br_cond;
  assign need_si20 = inst_lu12i_w | inst_pcaddu12i;
  assign need_si26 = inst_b | inst_bl;

  always_comb
  begin
    if (need_si20)
      imm = {inst[24:5], 12'b0};
    else if (need_ui5)
      imm = {{(xlen-5){1'b0}}, rk};
    else if (need_si26)
      imm = {{6{inst[9]}}, inst[9:0], inst[25:10]};
    else if (need_si16)
      imm = {{16{inst[25]}}, inst[25:10]};
    else if (need_ui12)
      imm = {20'b0, inst[21:10]};
    else if (need_si12)
      imm = {{20{inst[21]}}, inst[21:10]};
    else
      imm = '0;
  end

  always_comb
  begin
    if (inst_ld_w | inst_st_w)
      mem_width = 4'hf;
    else if (inst_ld_h | inst_ld_hu | inst_st_h)
      mem_width = 4'h3;
    else if (inst_ld_b | inst_ld_bu | inst_st_b)
      mem_width = 4'h1;
    else
      mem_width = 4'h0;
  end

  // unknown encodings fall through with every flag low
  assign gr_we         = alu_reg | alu_imm | inst_lu12i_w | inst_pcaddu12i | ld_any
                       | inst_jirl | inst_bl;
  assign use_rj        = alu_reg | alu_imm | ld_any | st_any | inst_jirl | br_cond;
  assign use_rkd       = alu_reg | st_any | br_cond;
  assign may_jump      = br_cond | inst_jirl | inst_b | inst_bl;
  assign src2_is_imm   = alu_imm | ld_any | st_any | inst_lu12i_w | inst_pcaddu12i;
  assign src_reg_is_rd = st_any | br_cond;
  assign dest          = inst_bl ? reg_addr_t'(1) : rd;

  assign rf_req.raddr1 = rj;
  assign rf_req.raddr2 = src_reg_is_rd ? rd : rk;

  always_comb
  begin
    slot.alu_op       = alu_op;
    slot.mem_width    = mem_width;
    slot.may_jump     = may_jump;
    slot.use_rj_value = inst_jirl;
    slot.use_less     = inst_blt | inst_bltu | inst_bge | inst_bgeu;
    slot.need_less    = inst_blt | inst_bltu;
    slot.use_zero     = inst_beq | inst_bne;
    slot.need_zero    = inst_beq;
    slot.src1_is_pc   = inst_jirl | inst_bl | inst_pcaddu12i;
    slot.src2_is_imm  = src2_is_imm;
    slot.src2_is_4    = inst_jirl | inst_bl;
    slot.gr_we        = gr_we;
    slot.mem_we       = st_any;
    slot.res_from_mem = ld_any;
    slot.is_unsigned  = inst_ld_bu | inst_ld_hu;
    slot.dest         = dest;
    slot.imm          = imm;
    slot.rj_value     = rf_data.rj_value;
    slot.rkd_value    = rf_data.rkd_value;
    slot.pc           = fetch.pc;
  end

  always_comb
  begin
    hazard.gr_we    = gr_we;
    hazard.dest     = dest;
    hazard.use_rj   = use_rj;
    hazard.use_rkd  = use_rkd;
    hazard.may_jump = may_jump;
    hazard.is_ls    = |mem_width;
  end

  // overlapping opcode constants would light two ALU ops
  always_comb
  begin
    a_alu_onehot: assert final ($onehot0(alu_op))
      else $error("alu_op %h not one-hot for inst %h", alu_op, inst);
  end

endmodule

/* design/issue_ctrl.sv */
`timescale 1ns/1ps

module issue_ctrl (
  input  decode_pkg::hazard_t haz0,
  input  decode_pkg::hazard_t haz1,
  input  decode_pkg::rf_req_t rf_req1,
  input  logic                fetch0_valid,
  input  logic                fetch1_valid,
  input  logic                exe_ready,
  output logic                issue0,
  output logic                issue1,
  output logic [1:0]          pop
);
  import decode_pkg::*;

  reg_addr_t wr0;
  logic      raw_rj;
  logic      raw_rkd;
  logic      need_single;

  // r0 writes never create a dependency
  assign wr0 = haz0.gr_we ? haz0.dest : '0;

  assign raw_rj  = haz1.use_rj && rf_req1.raddr1 == wr0;
  assign raw_rkd = haz1.use_rkd && rf_req1.raddr2 == wr0;

  // slot 1 waits behind jumps, memory ops and a RAW on slot 0
  assign need_single = haz0.may_jump
                     | haz0.is_ls
                     | haz1.is_ls
                     | ((wr0 != '0) && (raw_rj || raw_rkd));

  assign issue0 = fetch0_valid;
  assign issue1 = fetch1_valid & ~need_single;

  // fetch only pops what execute takes this edge
  assign pop = {issue1, issue0} & {2{exe_ready}};

endmodule

/* design/issue_reg.sv */
`timescale 1ns/1ps

module issue_reg (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  flush,
  input  logic                  exe_ready,
  input  logic                  issue0,
  input  logic                  issue1,
  input  decode_pkg::exe_slot_t slot0_in,
  input  decode_pkg::exe_slot_t slot1_in,
  output decode_pkg::exe_slot_t exe0,
  output decode_pkg::exe_slot_t exe1,
  output logic                  exe0_valid,
  output logic                  exe1_valid
);
  import decode_pkg::*;

  exe_slot_t  slot0_q;
  exe_slot_t  slot1_q;
  logic [1:0] valid_q;

  // flush wins over a load from decode
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      slot0_q <= '0;
      slot1_q <= '0;
      valid_q <= 2'b00;
    end
    else if (flush)
    begin
      slot0_q <= '0;
      slot1_q <= '0;
      valid_q <= 2'b00;
    end
    else if (exe_ready)
    begin
      slot0_q <= slot0_in;
      slot1_q <= slot1_in;
      valid_q <= {issue1, issue0};
    end
  end

  assign exe0       = slot0_q;
  assign exe1       = slot1_q;
  assign exe0_valid = valid_q[0];
  assign exe1_valid = valid_q[1];

  a_flush_clears: assert property (@(posedge clk) disable iff (!arst_n)
    flush |=> valid_q == 2'b00);

  a_stall_holds: assert property (@(posedge clk) disable iff (!arst_n)
    (!exe_ready && !flush) |=> $stable(valid_q) && $stable(slot0_q) && $stable(slot1_q));

endmodule

/* design/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage (
  input  logic                    clk,
  input  logic                    arst_n,
  input  decode_pkg::fetch_slot_t fetch0,
  input  decode_pkg::fetch_slot_t fetch1,
  input  logic                    fetch0_valid,
  input  logic                    fetch1_valid,
  output logic [1:0]              pop,
  input  logic                    exe_ready,
  input  logic                    flush,
  output decode_pkg::rf_req_t     rf_req0,
  output decode_pkg::rf_req_t     rf_req1,
  input  decode_pkg::rf_data_t    rf_data0,
  input  decode_pkg::rf_data_t    rf_data1,
  output decode_pkg::exe_slot_t   exe0,
  output decode_pkg::exe_slot_t   exe1,
  output logic                    exe0_valid,
  output logic                    exe1_valid
);
  import decode_pkg::*;

  exe_slot_t slot0;
  exe_slot_t slot1;
  hazard_t   haz0;
  hazard_t   haz1;
  logic      issue0;
  logic      issue1;

  inst_decoder u_dec0 (
    .fetch   (fetch0),
    .rf_data (rf_data0),
    .rf_req  (rf_req0),
    .slot    (slot0),
    .hazard  (haz0)
  );

  inst_decoder u_dec1 (
    .fetch   (fetch1),
    .rf_data (rf_data1),
    .rf_req  (rf_req1),
    .slot    (slot1),
    .hazard  (haz1)
  );

  // pairing only needs slot 1 read addresses
  issue_ctrl u_issue (
    .haz0         (haz0),
    .haz1         (haz1),
    .rf_req1      (rf_req1),
    .fetch0_valid (fetch0_valid),
    .fetch1_valid (fetch1_valid),
    .exe_ready    (exe_ready),
    .issue0       (issue0),
    .issue1       (issue1),
    .pop          (pop)
  );

  issue_reg u_reg (
    .clk        (clk),
    .arst_n     (arst_n),
    .flush      (flush),
    .exe_ready  (exe_ready),
    .issue0     (issue0),
    .issue1     (issue1),
    .slot0_in   (slot0),
    .slot1_in   (slot1),
    .exe0       (exe0),
    .exe1       (exe1),
    .exe0_valid (exe0_valid),
    .exe1_valid (exe1_valid)
  );

endmodule

/* test/tb_vectors.svh */
localparam int n_vec = 24;

// inst0, inst1, {fetch0_valid, fetch1_valid, exe_ready, flush}, pop, slot 0 raddr2
// then {exe1_valid, exe0_valid}, alu_op, dest, imm, gr_we, mem_width,
// {mem_we, res_from_mem, use_zero, need_zero, src2_is_4}
localparam vec_t vecs [n_vec] = '{
  // one class per row in slot 0, ori r20,r21 in slot 1
  '{32'h00100823, 32'h038016b4, 4'b1110, 2'b11, 5'd2,
    2'b11, 12'h001, 5'd3, 32'h00000000, 1'b1, 4'h0, 5'b00000},
  '{32'h02bff4a4, 32'h038016b4, 4'b1110, 2'b11, 5'd29,
    2'b11, 12'h001, 5'd4, 32'hfffffffd, 1'b1, 4'h0, 5'b00000},
  '{32'h036000e6, 32'h038016b4, 4'b1110, 2'b11, 5'd0,
    2'b11, 12'h010, 5'd6, 32'h00000800, 1'b1, 4'h0, 5'b00000},
  '{32'h00409528, 32'h038016b4, 4'b1110, 2'b11, 5'd5,
    2'b11, 12'h100, 5'd8, 32'h00000005, 1'b1, 4'h0, 5'b00000},
  '{32'h1500002a, 32'h038016b4, 4'b1110, 2'b11, 5'd0,
    2'b11, 12'h800, 5'd10, 32'h80001000, 1'b1, 4'h0, 5'b00000},
  '{32'h2840218b, 32'h038016b4, 4'b1110, 2'b01, 5'd8,
    2'b01, 12'h001, 5'd11, 32'h00000008, 1'b1, 4'h3, 5'b01000},
  '{32'h293ffdcd, 32'h038016b4, 4'b1110, 2'b01, 5'd13,
    2'b01, 12'h001, 5'd13, 32'hffffffff, 1'b0, 4'h1, 5'b10000},
  '{32'h5a001022, 32'h038016b4, 4'b1110, 2'b01, 5'd2,
    2'b01, 12'h002, 5'd2, 32'hffff8004, 1'b0, 4'h0, 5'b00110},
  '{32'h540043ff, 32'h038016b4, 4'b1110, 2'b01, 5'd16,
    2'b01, 12'h001, 5'd1, 32'hffff0010, 1'b1, 4'h0, 5'b00001},
  // unknown encoding
  '{32'hfc000000, 32'h038016b4, 4'b1110, 2'b11, 5'd0,
    2'b11, 12'h000, 5'd0, 32'h00000000, 1'b0, 4'h0, 5'b00000},
  // r3 hazards through rj, rk and store rd, then a load in slot 1
  '{32'h00100823, 32'h02800466, 4'b1110, 2'b01, 5'd2,
    2'b01, 12'h001, 5'd3, 32'h00000000, 1'b1, 4'h0, 5'b00000},
  '{32'h00100823, 32'h00100cc5, 4'b1110, 2'b01, 5'd2,
    2'b01, 12'h001, 5'd3, 32'h00000000, 1'b1, 4'h0, 5'b00000},
  '{32'h00100823, 32'h293ffdc3, 4'b1110, 2'b01, 5'd2,
    2'b01, 12'h001, 5'd3, 32'h00000000, 1'b1, 4'h0, 5'b00000},
  '{32'h00100823, 32'h2840218b, 4'b1110, 2'b01, 5'd2,
    2'b01, 12'h001, 5'd3, 32'h00000000, 1'b1, 4'h0, 5'b00000},
  // r0 write is no hazard
  '{32'h00100820, 32'h02800406, 4'b1110, 2'b11, 5'd2,
    2'b11, 12'h001, 5'd0, 32'h00000000, 1'b1, 4'h0, 5'b00000},
  '{32'h00100823, 32'h02bff4a4, 4'b1110, 2'b11, 5'd2,
    2'b11, 12'h001, 5'd3, 32'h00000000, 1'b1, 4'h0, 5'b00000},
  // stall
  '{32'h036000e6, 32'h038016b4, 4'b1100, 2'b00, 5'd0,
    2'b00, 12'h000, 5'd0, 32'h00000000, 1'b0, 4'h0, 5'b00000},
  '{32'h1500002a, 32'h038016b4, 4'b1100, 2'b00, 5'd0,
    2'b00, 12'h000, 5'd0, 32'h00000000, 1'b0, 4'h0, 5'b00000},
  '{32'h00409528, 32'h038016b4, 4'b1100, 2'b00, 5'd5,
    2'b00, 12'h000, 5'd0, 32'h00000000, 1'b0, 4'h0, 5'b00000},
  '{32'h036000e6, 32'h038016b4, 4'b1110, 2'b11, 5'd0,
    2'b11, 12'h010, 5'd6, 32'h00000800, 1'b1, 4'h0, 5'b00000},
  // flush beats ready
  '{32'h00100823, 32'h02bff4a4, 4'b1111, 2'b11, 5'd2,
    2'b00, 12'h000, 5'd0, 32'h00000000, 1'b0, 4'h0, 5'b00000},
  '{32'h00409528, 32'h038016b4, 4'b1110, 2'b11, 5'd5,
    2'b11, 12'h100, 5'd8, 32'h00000005, 1'b1, 4'h0, 5'b00000},
  '{32'h00100823, 32'h038016b4, 4'b1101, 2'b00, 5'd2,
    2'b00, 12'h000, 5'd0, 32'h00000000, 1'b0, 4'h0, 5'b00000},
  // nothing valid, payload still loads
  '{32'h00100823, 32'h038016b4, 4'b0010, 2'b00, 5'd2,
    2'b00, 12'h001, 5'd3, 32'h00000000, 1'b1, 4'h0, 5'b00000}
};

/* test/tb_decode_stage.sv */
`timescale 1ns/1ps

module tb_decode_stage;
  import decode_pkg::*;

  typedef struct packed {
    logic [31:0] inst0;
    logic [31:0] inst1;
    logic [3:0]  ctl;
    logic [1:0]  pop;
    reg_addr_t   rkd0;
    logic [1:0]  valid;
    alu_op_t     alu_op;
    reg_addr_t   dest;
    logic [31:0] imm;
    logic        gr_we;
    logic [3:0]  mem_width;
    logic [4:0]  flags;
  } vec_t;

  localparam int  reset_cycles  = 16;
  localparam int  release_limit = 8;
  localparam time run_limit     = 200us;

  `include "tb_vectors.svh"

  logic        clk;
  logic        arst_n;
  fetch_slot_t fetch0;
  fetch_slot_t fetch1;
  logic        fetch0_valid;
  logic        fetch1_valid;
  logic [1:0]  pop;
  logic        exe_ready;
  logic        flush;
  rf_req_t     rf_req0;
  rf_req_t     rf_req1;
  rf_data_t    rf_data0;
  rf_data_t    rf_data1;
  exe_slot_t   exe0;
  exe_slot_t   exe1;
  logic        exe0_valid;
  logic        exe1_valid;

  integer      seed = 32'he8d0;

  // what the register should hold after the last edge
  vec_t        exp_row;
  logic [31:0] exp_pc0;
  logic [31:0] exp_pc1;

  decode_stage u_dut (
    .clk          (clk),
    .arst_n       (arst_n),
    .fetch0       (fetch0),
    .fetch1       (fetch1),
    .fetch0_valid (fetch0_valid),
    .fetch1_valid (fetch1_valid),
    .pop          (pop),
    .exe_ready    (exe_ready),
    .flush        (flush),
    .rf_req0      (rf_req0),
    .rf_req1      (rf_req1),
    .rf_data0     (rf_data0),
    .rf_data1     (rf_data1),
    .exe0         (exe0),
    .exe1         (exe1),
    .exe0_valid   (exe0_valid),
    .exe1_valid   (exe1_valid)
  );

  // register file answers with the index in every byte
  function automatic logic [31:0] reg_pattern(input reg_addr_t idx);
    return {4{3'b000, idx}};
  endfunction

  assign rf_data0 = {reg_pattern(rf_req0.raddr1), reg_pattern(rf_req0.raddr2)};
  assign rf_data1 = {reg_pattern(rf_req1.raddr1), reg_pattern(rf_req1.raddr2)};

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic fail_run(input string why);
    $display("Something failed");
    $fatal(1, "%s", why);
  endtask

  task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp)
    begin
      $display("[FAIL] %s: got %0h, expected %0h", name, got, exp);
      fail_run("value mismatch");
    end
  endtask

  task automatic hold_reset();
    int n;
    n = 0;
    while (n < reset_cycles)
    begin
      @(posedge clk);
      n++;
    end
    arst_n <= 1'b1;
  endtask

  task automatic wait_reset_release();
    int waited;
    waited = 0;
    while (arst_n !== 1'b1 && waited < release_limit)
    begin
      @(posedge clk);
      waited++;
    end
    if (arst_n !== 1'b1)
      fail_run("reset was never released");
  endtask

  task automatic drive_row(input vec_t v, input logic [31:0] pc0, input logic [31:0] pc1);
    fetch0       <= '{pc: pc0, inst: v.inst0};
    fetch1       <= '{pc: pc1, inst: v.inst1};
    fetch0_valid <= v.ctl[3];
    fetch1_valid <= v.ctl[2];
    exe_ready    <= v.ctl[1];
    flush        <= v.ctl[0];
  endtask

  // flush clears, ready loads, otherwise the pair stays
  task automatic update_model(input vec_t v, input logic [31:0] pc0, input logic [31:0] pc1);
    if (v.ctl[0])
    begin
      exp_row = '0;
      exp_pc0 = '0;
      exp_pc1 = '0;
    end
    else if (v.ctl[1])
    begin
      exp_row = v;
      exp_pc0 = pc0;
      exp_pc1 = pc1;
    end
  endtask

  task automatic check_exe();
    logic [4:0] flags;
    flags = {exe0.mem_we, exe0.res_from_mem, exe0.use_zero, exe0.need_zero, exe0.src2_is_4};
    check_eq("exe0_valid", 64'(exe0_valid), 64'(exp_row.valid[0]));
    check_eq("exe1_valid", 64'(exe1_valid), 64'(exp_row.valid[1]));
    check_eq("exe0.alu_op", 64'(exe0.alu_op), 64'(exp_row.alu_op));
    check_eq("exe0.dest", 64'(exe0.dest), 64'(exp_row.dest));
    check_eq("exe0.imm", 64'(exe0.imm), 64'(exp_row.imm));
    check_eq("exe0.gr_we", 64'(exe0.gr_we), 64'(exp_row.gr_we));
    check_eq("exe0.mem_width", 64'(exe0.mem_width), 64'(exp_row.mem_width));
    check_eq("exe0 flags", 64'(flags), 64'(exp_row.flags));
    check_eq("exe0.rj_value", 64'(exe0.rj_value), 64'(reg_pattern(exp_row.inst0[9:5])));
    check_eq("exe0.rkd_value", 64'(exe0.rkd_value), 64'(reg_pattern(exp_row.rkd0)));
    check_eq("exe0.pc", 64'(exe0.pc), 64'(exp_pc0));
    check_eq("exe1.rj_value", 64'(exe1.rj_value), 64'(reg_pattern(exp_row.inst1[9:5])));
    check_eq("exe1.pc", 64'(exe1.pc), 64'(exp_pc1));
  endtask

  initial
  begin
    run_watchdog();
  end

  task automatic run_watchdog();
    #(run_limit);
    fail_run("simulation ran past its time limit");
  endtask

  initial
  begin : main
    int          i;
    logic [31:0] pc0;
    logic [31:0] pc1;
    arst_n       <= 1'b0;
    fetch0       <= '0;
    fetch1       <= '0;
    fetch0_valid <= 1'b0;
    fetch1_valid <= 1'b0;
    exe_ready    <= 1'b1;
    flush        <= 1'b0;
    exp_row = '0;
    exp_pc0 = '0;
    exp_pc1 = '0;

    hold_reset();
    wait_reset_release();
    @(negedge clk);
    check_exe();
    check_eq("pop", 64'(pop), 64'(2'b00));

    for (i = 0; i < n_vec; i++)
    begin
      @(posedge clk);
      pc0 = $random(seed);
      pc0[1:0] = 2'b00;
      pc1 = pc0 + 32'd4;
      drive_row(vecs[i], pc0, pc1);
      @(negedge clk);
      // register shows the row before this one
      check_exe();
      check_eq("pop", 64'(pop), 64'(vecs[i].pop));
      check_eq("rf_req0.raddr1", 64'(rf_req0.raddr1), 64'(vecs[i].inst0[9:5]));
      check_eq("rf_req0.raddr2", 64'(rf_req0.raddr2), 64'(vecs[i].rkd0));
      check_eq("rf_req1.raddr1", 64'(rf_req1.raddr1), 64'(vecs[i].inst1[9:5]));
      update_model(vecs[i], pc0, pc1);
    end

    @(posedge clk);
    fetch0_valid <= 1'b0;
    fetch1_valid <= 1'b0;
    flush        <= 1'b0;
    @(negedge clk);
    check_exe();

    $display("Everything OK");
    $finish;
  end

endmodule

/* dual_decode.f */
+incdir+test
design/decode_pkg.sv
design/inst_decoder.sv
design/issue_ctrl.sv
design/issue_reg.sv
design/decode_stage.sv
test/tb_decode_stage.sv

/* Makefile */
obj_dir/Vtb_decode_stage: dual_decode.f $(wildcard design/*.sv test/*.sv test/*.svh)
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f dual_decode.f --top-module tb_decode_stage -o Vtb_decode_stage

run: obj_dir/Vtb_decode_stage
	./obj_dir/Vtb_decode_stage

clean:
	rm -rf obj_dir

.PHONY: run clean
